// File: rtl/overlayPkg.sv
package overlayPkg;

    // A pixel coordinate as supplied by the scan generator.
    typedef logic [10:0] coord_t;

    // A color holds 4 bits per channel with r in the low nibble, then g, then b.
    typedef logic [11:0] rgb_t;

    // One statistic is shown as four hex digits.
    typedef logic [15:0] statValue_t;
    typedef logic [3:0] digit_t;
    typedef logic [2:0] statIndex_t;

    // NUM_STATS may be set anywhere from 1 up to this bound.
    localparam int MAX_STATS = 8;
    localparam int DIGITS_PER_STAT = 4;

    // Each cell is 8 by 8 pixels, so cell addressing is a plain bit slice.
    localparam int CELL_SHIFT = 3;
    localparam int GLYPH_SIZE = 7;

    typedef logic [7:0] apbAddr_t;
    typedef logic [31:0] apbData_t;

    // Register map of the APB block.
    localparam apbAddr_t ADDR_BACKGROUND = 8'h00;
    localparam apbAddr_t ADDR_STAT_BASE = 8'h04;

    typedef struct packed {
        logic psel;
        logic penable;
        logic pwrite;
        apbAddr_t paddr;
        apbData_t pwdata;
    } apbReq_t;

    typedef struct packed {
        apbData_t prdata;
        logic pready;
        logic pslverr;
    } apbRsp_t;

    // Position of a pixel inside the text window, produced by pipeline stage 1.
    typedef struct packed {
        logic inWindow;
        statIndex_t statIndex;
        logic [1:0] digitIndex;
        logic [2:0] glyphRow;
        logic [2:0] glyphCol;
    } cellPos_t;

    typedef statValue_t [MAX_STATS-1:0] statArray_t;

endpackage

// File: rtl/overlayConfig.sv
`timescale 1ns/10ps

module overlayConfig #(
    parameter int NUM_STATS = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  overlayPkg::apbReq_t    apbReq,
    output overlayPkg::apbRsp_t    apbRsp,
    output overlayPkg::rgb_t       background,
    output overlayPkg::statArray_t stats
);

    logic setupPhase;
    logic accessPhase;
    logic aligned;
    logic isBackground;
    logic isStat;
    logic addrError;
    overlayPkg::apbAddr_t statOffset;
    logic [$bits(overlayPkg::apbAddr_t)-3:0] statWord;
    overlayPkg::statIndex_t statSel;
    overlayPkg::apbData_t readData;
    overlayPkg::rgb_t backgroundReg;
    overlayPkg::statArray_t statRegs;
    overlayPkg::apbData_t rspData;
    logic rspErr;

    // The setup phase lasts one cycle and is always followed by the access phase.
    assign setupPhase = apbReq.psel && !apbReq.penable;
    assign accessPhase = apbReq.psel && apbReq.penable;

    // Statistics sit on consecutive words starting at ADDR_STAT_BASE.
    assign aligned = (apbReq.paddr[1:0] == 2'b00);
    assign statOffset = apbReq.paddr - overlayPkg::ADDR_STAT_BASE;
    assign statWord = statOffset[$bits(overlayPkg::apbAddr_t)-1:2];
    assign statSel = overlayPkg::statIndex_t'(statWord);

    assign isBackground = (apbReq.paddr == overlayPkg::ADDR_BACKGROUND);
    // Words past the configured number of statistics are not mapped.
    assign isStat = aligned
                    && (apbReq.paddr >= overlayPkg::ADDR_STAT_BASE)
                    && (statWord < NUM_STATS);
    assign addrError = !(isBackground || isStat);

    // An unmapped read yields zero because neither branch is taken.
    always_comb begin
        readData = '0;
        if (isBackground) begin
            readData = overlayPkg::apbData_t'(backgroundReg);
        end else if (isStat) begin
            readData = overlayPkg::apbData_t'(statRegs[statSel]);
        end
    end

    // A write lands on the edge that closes the access phase.
    // Statistics beyond NUM_STATS can never be written and stay at zero.
    always_ff @(posedge clk) begin
        if (reset) begin
            backgroundReg <= '0;
            statRegs <= '0;
        end else if (accessPhase && apbReq.pwrite && !addrError) begin
            if (isBackground) begin
                backgroundReg <= overlayPkg::rgb_t'(apbReq.pwdata);
            end
            if (isStat) begin
                statRegs[statSel] <= overlayPkg::statValue_t'(apbReq.pwdata);
            end
        end
    end

    // The response is prepared during setup so that it is stable for the whole access phase.
    // It drops back to zero on every other cycle.
    always_ff @(posedge clk) begin
        if (reset) begin
            rspData <= '0;
            rspErr <= 1'b0;
        end else if (setupPhase) begin
            rspData <= apbReq.pwrite ? '0 : readData;
            rspErr <= addrError;
        end else begin
            rspData <= '0;
            rspErr <= 1'b0;
        end
    end

    // There are no wait states.
    assign apbRsp = '{prdata: rspData, pready: 1'b1, pslverr: rspErr};

    assign background = backgroundReg;
    assign stats = statRegs;

    // An error may only be flagged while the master sits in the access phase.
    // This fails if the setup phase is stretched past one cycle.
    errOnlyInAccess: assert property (@(posedge clk) disable iff (reset)
        apbRsp.pslverr |-> (apbReq.psel && apbReq.penable));

    // The master must never raise penable without psel.
    enableNeedsSelect: assert property (@(posedge clk) disable iff (reset)
        apbReq.penable |-> apbReq.psel);

endmodule

// File: rtl/cellLocator.sv
`timescale 1ns/10ps

module cellLocator #(
    parameter int NUM_STATS = 4,
    parameter int ORIGIN_X = 30,
    parameter int ORIGIN_Y = 30
) (
    input  logic                 clk,
    input  logic                 reset,
    input  overlayPkg::coord_t   x,
    input  overlayPkg::coord_t   y,
    output overlayPkg::cellPos_t cellPos
);

    // The window is one row of cells per statistic and one column per digit.
    localparam int WINDOW_W = overlayPkg::DIGITS_PER_STAT << overlayPkg::CELL_SHIFT;
    localparam int WINDOW_H = NUM_STATS << overlayPkg::CELL_SHIFT;
    localparam overlayPkg::coord_t ORG_X = overlayPkg::coord_t'(ORIGIN_X);
    localparam overlayPkg::coord_t ORG_Y = overlayPkg::coord_t'(ORIGIN_Y);

    overlayPkg::coord_t offX;
    overlayPkg::coord_t offY;
    overlayPkg::cellPos_t nextPos;

    // Offsets relative to the top left corner of the window.
    assign offX = x - ORG_X;
    assign offY = y - ORG_Y;

    always_comb begin
        // The pixel must lie at or past the origin and within the window size.
        nextPos.inWindow = (x >= ORG_X) && (y >= ORG_Y)
                           && (offX < overlayPkg::coord_t'(WINDOW_W))
                           && (offY < overlayPkg::coord_t'(WINDOW_H));
        // Cell row picks the statistic and cell column picks the digit.
        nextPos.statIndex = offY[overlayPkg::CELL_SHIFT +: $bits(overlayPkg::statIndex_t)];
        nextPos.digitIndex = offX[overlayPkg::CELL_SHIFT +: 2];
        // The low bits address a pixel in the cell.
        // Row 7 and column 7 form the blank spacing around each glyph.
        nextPos.glyphRow = offY[overlayPkg::CELL_SHIFT-1:0];
        nextPos.glyphCol = offX[overlayPkg::CELL_SHIFT-1:0];
    end

    // Stage 1 register.
    always_ff @(posedge clk) begin
        if (reset) begin
            cellPos <= '0;
        end else begin
            cellPos <= nextPos;
        end
    end

    // The window height keeps every lit pixel on a configured statistic.
    statInRange: assert property (@(posedge clk) disable iff (reset)
        cellPos.inWindow |-> (cellPos.statIndex < NUM_STATS));

endmodule

// File: rtl/textRenderer.sv
`timescale 1ns/10ps

module textRenderer #(
    parameter int NUM_STATS = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  overlayPkg::cellPos_t   cellPos,
    input  overlayPkg::rgb_t       background,
    input  overlayPkg::statArray_t stats,
    output overlayPkg::rgb_t       rgb
);

    localparam int GLYPH_BITS = overlayPkg::GLYPH_SIZE * overlayPkg::GLYPH_SIZE;

    // Returns one row of a glyph with column 0 in the MSB.
    // Row 0 of each glyph sits in the top 7 bits of the constant.
    function automatic logic [overlayPkg::GLYPH_SIZE-1:0] fontRow(
        overlayPkg::digit_t digit,
        logic [2:0] row
    );
        logic [GLYPH_BITS-1:0] glyph;
        case (digit)
            4'h0: glyph = 49'b0011100_0100010_0100110_0101010_0110010_0100010_0011100;
            4'h1: glyph = 49'b0001000_0011000_0101000_0001000_0001000_0001000_0111110;
            4'h2: glyph = 49'b0011100_0100010_0000010_0000100_0001000_0010000_0111110;
            4'h3: glyph = 49'b0111110_0000010_0000100_0001100_0000010_0100010_0011100;
            4'h4: glyph = 49'b0000100_0001100_0010100_0100100_0111110_0000100_0000100;
            4'h5: glyph = 49'b0111110_0100000_0111100_0000010_0000010_0100010_0011100;
            4'h6: glyph = 49'b0011100_0100000_0100000_0111100_0100010_0100010_0011100;
            4'h7: glyph = 49'b0111110_0000010_0000100_0001000_0010000_0010000_0010000;
            4'h8: glyph = 49'b0011100_0100010_0100010_0011100_0100010_0100010_0011100;
            4'h9: glyph = 49'b0011100_0100010_0100010_0011110_0000010_0000010_0011100;
            4'hA: glyph = 49'b0011100_0100010_0100010_0111110_0100010_0100010_0100010;
            4'hB: glyph = 49'b0111100_0100010_0100010_0111100_0100010_0100010_0111100;
            4'hC: glyph = 49'b0011100_0100010_0100000_0100000_0100000_0100010_0011100;
            4'hD: glyph = 49'b0111100_0100010_0100010_0100010_0100010_0100010_0111100;
            4'hE: glyph = 49'b0111110_0100000_0100000_0111100_0100000_0100000_0111110;
            default: glyph = 49'b0111110_0100000_0100000_0111100_0100000_0100000_0100000;
        endcase
        // The spacing row under the glyph is always blank.
        if (row >= 3'(overlayPkg::GLYPH_SIZE)) begin
            return '0;
        end
        return glyph[GLYPH_BITS - 1 - overlayPkg::GLYPH_SIZE * row -: overlayPkg::GLYPH_SIZE];
    endfunction

    overlayPkg::statValue_t selValue;
    overlayPkg::digit_t digit;
    logic [overlayPkg::GLYPH_SIZE-1:0] rowBits;
    logic [overlayPkg::GLYPH_SIZE:0] cellBits;
    logic rowActive;
    logic litNext;
    logic litStage2;
    overlayPkg::rgb_t bgStage2;

    always_comb begin
        selValue = stats[cellPos.statIndex];
        // Digit 0 is the most significant nibble, so the shift is 4 times (3 - digitIndex).
        digit = overlayPkg::digit_t'(selValue >> {~cellPos.digitIndex, 2'b00});
        rowBits = fontRow(digit, cellPos.glyphRow);
        // A zero is appended as column 7, the blank column on the right of the cell.
        cellBits = {rowBits, 1'b0};
        // Rows past the configured statistics never light up.
        rowActive = cellPos.inWindow && (cellPos.statIndex < NUM_STATS);
        litNext = rowActive && cellBits[~cellPos.glyphCol];
    end

    // Stage 2 takes the background along with the lit flag.
    // Each pixel keeps the color that was current when it passed here.
    always_ff @(posedge clk) begin
        if (reset) begin
            litStage2 <= 1'b0;
        end else begin
            litStage2 <= litNext;
        end
    end

    always_ff @(posedge clk) begin
        bgStage2 <= background;
    end

    // Stage 3 inverts every channel on lit glyph pixels.
    always_ff @(posedge clk) begin
        if (reset) begin
            rgb <= '0;
        end else begin
            rgb <= litStage2 ? ~bgStage2 : bgStage2;
        end
    end

    // The output color carries no unknown bits once out of reset.
    rgbKnown: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(rgb));

endmodule

// File: rtl/statsOverlay.sv
`timescale 1ns/10ps

module statsOverlay #(
    parameter int NUM_STATS = 4,
    parameter int ORIGIN_X = 30,
    parameter int ORIGIN_Y = 30
) (
    input  logic                clk,
    input  logic                reset,
    input  overlayPkg::coord_t  x,
    input  overlayPkg::coord_t  y,
    input  overlayPkg::apbReq_t apbReq,
    output overlayPkg::apbRsp_t apbRsp,
    output overlayPkg::rgb_t    rgb
);

    overlayPkg::rgb_t background;
    overlayPkg::statArray_t stats;
    overlayPkg::cellPos_t cellPos;

    // Register block holding the background color and the statistic values.
    overlayConfig #(
        .NUM_STATS(NUM_STATS)
    ) i_overlayConfig (
        .clk(clk),
        .reset(reset),
        .apbReq(apbReq),
        .apbRsp(apbRsp),
        .background(background),
        .stats(stats)
    );

    // Pixel stage 1 turns the scan position into a cell address.
    cellLocator #(
        .NUM_STATS(NUM_STATS),
        .ORIGIN_X(ORIGIN_X),
        .ORIGIN_Y(ORIGIN_Y)
    ) i_cellLocator (
        .clk(clk),
        .reset(reset),
        .x(x),
        .y(y),
        .cellPos(cellPos)
    );

    // Pixel stages 2 and 3 do the font lookup and the final color.
    textRenderer #(
        .NUM_STATS(NUM_STATS)
    ) i_textRenderer (
        .clk(clk),
        .reset(reset),
        .cellPos(cellPos),
        .background(background),
        .stats(stats),
        .rgb(rgb)
    );

endmodule

// File: bench/statsOverlay_tb.sv
`timescale 1ns/10ps

module statsOverlay_tb;

    logic clk;
    logic reset;
    overlayPkg::coord_t x;
    overlayPkg::coord_t y;
    overlayPkg::apbReq_t apbReq;
    overlayPkg::apbRsp_t apbRsp;
    overlayPkg::rgb_t rgb;

    int seed;
    int cycle;
    int testCount;
    int failCount;

    // Pixel probes still in the pipeline, oldest first.
    int dueQ[$];
    overlayPkg::rgb_t expQ[$];
    string nameQ[$];

    statsOverlay i_statsOverlay (
        .clk(clk),
        .reset(reset),
        .x(x),
        .y(y),
        .apbReq(apbReq),
        .apbRsp(apbRsp),
        .rgb(rgb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic endTest(input string name, input bit ok);
        testCount++;
        if (ok) begin
            $display("test %s passed", name);
        end else begin
            failCount++;
            $display("test %s failed", name);
        end
    endtask

    task automatic compare(input string name, input string what, input logic [31:0] expVal,
                           input logic [31:0] actVal, inout bit ok);
        assert (actVal === expVal) else begin
            $display("MISMATCH %s %s expected %h actual %h", name, what, expVal, actVal);
            ok = 1'b0;
        end
    endtask

    // Advances to the next falling edge and retires every probe whose result is due.
    // Pixel inputs default to random scan positions that nobody checks.
    task automatic tick();
        bit ok;
        @(negedge clk);
        cycle++;
        while (dueQ.size() > 0 && dueQ[0] == cycle) begin
            ok = 1'b1;
            compare(nameQ[0], "rgb", 32'(expQ[0]), 32'(rgb), ok);
            endTest(nameQ[0], ok);
            void'(dueQ.pop_front());
            void'(expQ.pop_front());
            void'(nameQ.pop_front());
        end
        x = overlayPkg::coord_t'($random(seed));
        y = overlayPkg::coord_t'($random(seed));
    endtask

    // One APB transfer of setup, access and a trailing idle cycle.
    // The response is sampled in the middle of the access phase.
    task automatic apbAccess(input logic write, input overlayPkg::apbAddr_t addr,
                             input overlayPkg::apbData_t data,
                             output overlayPkg::apbData_t rdata, output logic err,
                             output logic rdy);
        tick();
        apbReq.psel = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite = write;
        apbReq.paddr = addr;
        apbReq.pwdata = data;
        tick();
        apbReq.penable = 1'b1;
        rdata = apbRsp.prdata;
        err = apbRsp.pslverr;
        rdy = apbRsp.pready;
        tick();
        apbReq = '0;
    endtask

    task automatic runCommand(input string name, input string cmd,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] expVal, input logic [31:0] expErr);
        overlayPkg::apbData_t rdata;
        logic err;
        logic rdy;
        bit ok;
        ok = 1'b1;
        if (cmd == "pixel") begin
            tick();
            x = overlayPkg::coord_t'(a);
            y = overlayPkg::coord_t'(b);
            // The color appears after three rising edges, which is three falling edges on.
            dueQ.push_back(cycle + 3);
            expQ.push_back(overlayPkg::rgb_t'(expVal));
            nameQ.push_back(name);
        end else if (cmd == "write" || cmd == "read") begin
            apbAccess(cmd == "write", a[7:0], b, rdata, err, rdy);
            if (cmd == "read") begin
                compare(name, "prdata", expVal, rdata, ok);
            end
            compare(name, "pslverr", expErr, 32'(err), ok);
            // The register block never inserts wait states.
            compare(name, "pready", 32'd1, 32'(rdy), ok);
            endTest(name, ok);
        end else begin
            $display("Test %s uses the unknown command %s.", name, cmd);
            endTest(name, 1'b0);
        end
    endtask

    initial begin
        int fd;
        int n;
        string line;
        string name;
        string cmd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expVal;
        logic [31:0] expErr;
        seed = 32'hbc721001;
        cycle = 0;
        testCount = 0;
        failCount = 0;
        reset = 1'b1;
        x = '0;
        y = '0;
        apbReq = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        fd = $fopen("bench/overlay_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file bench/overlay_golden.txt.");
            failCount++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%s %s %h %h %h %h", name, cmd, a, b, expVal, expErr);
                // Lines starting with a hash are column notes.
                if (line.getc(0) != "#" && n == 6) begin
                    runCommand(name, cmd, a, b, expVal, expErr);
                end else if (line.getc(0) != "#" && n > 0) begin
                    $display("A golden file line has %0d fields instead of 6: %s", n, line);
                    failCount++;
                end
            end
            $fclose(fd);
            // Let the last probes leave the pipeline.
            while (dueQ.size() > 0) begin
                tick();
            end
        end
        $display("%0d tests run, %0d failed", testCount, failCount);
        if (failCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the golden file.
    initial begin
        int fd;
        int lines;
        string line;
        lines = 0;
        fd = $fopen("bench/overlay_golden.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                lines++;
            end
            $fclose(fd);
        end
        // Each line gets 40 clock periods; the margin covers reset and the drain.
        #(lines * 40 * 20 + 1000);
        $display("Timeout: the run did not finish within the time allowed for %0d lines.", lines);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: bench/overlay_golden.txt
# name command a b expected pslverr, all numbers in hex
# write: a=addr b=data; read: a=addr expected=prdata; pixel: a=x b=y expected=rgb
rst_in_unlit pixel 1e 1e 000 0
rst_in_lit pixel 20 1e fff 0
rst_outside pixel a a 000 0
wr_bg write 00 5a3 0 0
wr_s0 write 04 0123 0 0
wr_s1 write 08 4567 0 0
wr_s2 write 0c 89ab 0 0
wr_s3 write 10 cdef 0 0
rd_bg read 00 0 5a3 0
rd_s0 read 04 0 123 0
rd_s1 read 08 0 4567 0
rd_s2 read 0c 0 89ab 0
rd_s3 read 10 0 cdef 0
rd_unmapped read 40 0 0 1
wr_unmapped write 40 ffff 0 1
rd_stat4 read 14 0 0 1
wr_stat4 write 14 1234 0 1
rd_unaligned read 06 0 0 1
out_10_10 pixel a a 5a3 0
out_70_40 pixel 46 28 5a3 0
out_right pixel 3e 1e 5a3 0
out_below pixel 1e 3e 5a3 0
one_lit pixel 29 1e a5c 0
one_blank pixel 26 1e 5a3 0
one_base pixel 27 24 a5c 0
one_col7 pixel 2d 24 5a3 0
one_row7 pixel 29 25 5a3 0
b_lit pixel 37 2e a5c 0
b_blank pixel 3b 2e 5a3 0
d_lit pixel 2b 39 a5c 0
d_blank pixel 29 39 5a3 0
one_c2 pixel 28 1e 5a3 0
wr_s0_new write 04 0823 0 0
eight_c2 pixel 28 1e a5c 0
eight_r1 pixel 29 1f 5a3 0
b2b0 pixel 1e 1e 5a3 0
b2b1 pixel 20 1e a5c 0
b2b2 pixel a a 5a3 0
b2b3 pixel 28 1e a5c 0
b2b4 pixel 29 1f 5a3 0
b2b5 pixel 37 2e a5c 0
b2b6 pixel 2d 24 5a3 0
b2b7 pixel 2b 39 a5c 0

// File: verilog.f
rtl/overlayPkg.sv
rtl/overlayConfig.sv
rtl/cellLocator.sv
rtl/textRenderer.sv
rtl/statsOverlay.sv
bench/statsOverlay_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= statsOverlay_tb
FLAGS ?= --binary --timing --assert
OBJ_DIR ?= obj_dir
FILELIST ?= verilog.f

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
